// File: files.f
rtl/mem_unit_pkg.sv
rtl/load_store_queue.sv
rtl/mem_issue_ctrl.sv
rtl/mem_resp_pipe.sv
rtl/mem_writeback.sv
rtl/mem_unit.sv
verif/mem_unit_checker.sv
verif/mem_unit_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module mem_unit_tb -f files.f -o sim

run: build
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	@if grep -q "Checks failed" sim.log; then exit 1; fi
	@grep -q "All checks passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module mem_unit_tb -f files.f

clean:
	rm -rf obj_dir sim.log

// File: verif/mem_unit_tb.sv
// Cache model answers two cycles after a request; ready, nack and fault flags come from each test
`default_nettype none

module mem_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_unit_pkg::*;

    typedef struct packed {
        logic        is_store;
        logic        nack;      // Cache nacks the first attempt
        logic        ma;
        logic        pf;
        xlen_t       addr;
        xlen_t       data;
        logic        exp_xcpt;
        xcpt_cause_e exp_cause;
    } row_t;

    localparam int NUM_ROWS = 7;

    logic         clk_i = 1'b0;
    logic         rstn_i;
    logic         flush_i;
    logic         commit_store_i;
    mem_instr_t   instr_i;
    dcache_resp_t dcache_resp_i;
    dcache_req_t  dcache_req_o;
    wb_t          wb_o;
    exception_t   xcpt_commit_o;
    logic         commit_stall_o;
    gl_index_t    store_gl_index_o;
    logic         lock_o;
    logic         empty_o;

    row_t  rows [NUM_ROWS];
    string names [NUM_ROWS];
    xlen_t mem [16];        // Cache model contents
    xlen_t golden [16];     // Expected memory, updated by the tests
    int    errors = 0;
    int    checks = 0;
    int    tests  = 0;

    // Cache model controls
    logic  ready_en = 1'b1;
    logic  ma_en = 1'b0;
    logic  pf_en = 1'b0;
    int    nack_req = 0;
    int    nack_used = 0;
    logic  p1_vld = 1'b0;
    logic  p1_store = 1'b0;
    xlen_t p1_addr = '0;
    logic  p2_vld = 1'b0;
    logic  p2_store = 1'b0;
    xlen_t p2_addr = '0;
    xlen_t p2_data = '0;

    // Monitor totals
    int    wb_total = 0;
    int    req_total = 0;
    int    kill_total = 0;
    xlen_t last_addr = '0;
    xlen_t prev_addr = '0;

    mem_unit DUT (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .flush_i          (flush_i),
        .instr_i          (instr_i),
        .commit_store_i   (commit_store_i),
        .dcache_resp_i    (dcache_resp_i),
        .dcache_req_o     (dcache_req_o),
        .wb_o             (wb_o),
        .xcpt_commit_o    (xcpt_commit_o),
        .commit_stall_o   (commit_stall_o),
        .store_gl_index_o (store_gl_index_o),
        .lock_o           (lock_o),
        .empty_o          (empty_o)
    );

    initial begin
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////
    // Cache model
    ////////////////////

    always @(posedge clk_i) begin
        if (dcache_req_o.kill) begin
            p1_vld <= 1'b0;
            p2_vld <= 1'b0;
        end else begin
            p1_vld   <= dcache_req_o.valid;
            p1_store <= dcache_req_o.is_store;
            p1_addr  <= dcache_req_o.addr;
            p2_vld   <= p1_vld;
            p2_store <= p1_store;
            p2_addr  <= p1_addr;
            p2_data  <= dcache_req_o.store_data;  // Data trails its request by a cycle
        end
    end

    always @(negedge clk_i) begin
        dcache_resp_t r;
        r       = '0;
        r.ready = ready_en;
        if (p2_vld) begin
            if (nack_used != nack_req) begin
                r.nack    = 1'b1;
                nack_used = nack_used + 1;
            end else begin
                r.valid   = 1'b1;
                r.xcpt_ma = ma_en;
                r.xcpt_pf = pf_en;
                if (!p2_store) begin
                    r.data = mem[p2_addr[6:3]];
                end else if (!ma_en && !pf_en) begin
                    mem[p2_addr[6:3]] = p2_data;
                end
            end
        end
        dcache_resp_i = r;
    end

    always @(posedge clk_i) begin
        if (rstn_i) begin
            if (wb_o.valid) wb_total <= wb_total + 1;
            if (dcache_req_o.kill) kill_total <= kill_total + 1;
            if (dcache_req_o.valid) begin
                req_total <= req_total + 1;
                prev_addr <= last_addr;
                last_addr <= dcache_req_o.addr;
            end
        end
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        logic bad;
        checks++;
        bad = (exp.valid !== act.valid) || (exp.rd !== act.rd) ||
              (exp.gl_index !== act.gl_index) || (exp.result !== act.result) ||
              (exp.ex.valid !== act.ex.valid);
        if (exp.ex.valid && ((exp.ex.cause !== act.ex.cause) ||
                             (exp.ex.origin !== act.ex.origin)))
            bad = 1'b1;
        if (bad) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_xcpt(input string name, input exception_t exp, input exception_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_index(input string name, input gl_index_t exp, input gl_index_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int errs0);
        tests++;
        if (errors == errs0) $display("test %s ok", name);
        else $display("test %s had %0d errors", name, errors - errs0);
    endtask

    task automatic push_load(input xlen_t addr, input int tagno);
        @(negedge clk_i);
        instr_i          = '0;
        instr_i.valid    = 1'b1;
        instr_i.size     = SIZE_D;
        instr_i.rd       = reg_addr_t'(tagno);
        instr_i.gl_index = gl_index_t'(tagno + 10);
        instr_i.base     = addr - 64'd8;
        instr_i.imm      = 64'd8;
    endtask

    function automatic wb_t expect_load(input xlen_t addr, input int tagno);
        wb_t e;
        e          = '0;
        e.valid    = 1'b1;
        e.rd       = reg_addr_t'(tagno);
        e.gl_index = gl_index_t'(tagno + 10);
        e.result   = golden[addr[6:3]];
        return e;
    endfunction

    ////////////////////
    // Table rows
    ////////////////////

    task automatic run_row(input int i);
        row_t       r;
        wb_t        exp_wb;
        wb_t        act_wb;
        exception_t exp_x;
        exception_t act_x;
        int         errs0;
        int         wb0;
        int         req0;
        int         kill0;
        logic       got;
        logic       stall_seen;
        r     = rows[i];
        errs0 = errors;
        ma_en = r.ma;
        pf_en = r.pf;
        if (r.nack) nack_req = nack_req + 1;
        wb0   = wb_total;
        kill0 = kill_total;
        push_load(r.addr, i + 1);
        instr_i.is_store   = r.is_store;
        instr_i.store_data = r.data;
        req0  = req_total;
        @(negedge clk_i);
        instr_i = '0;
        if (r.is_store) begin
            repeat (6) @(negedge clk_i);
            check_flag({names[i], " no request before commit"}, 1'b0, req_total != req0);
            commit_store_i = 1'b1;
            act_x      = '0;
            stall_seen = 1'b0;
            got        = 1'b0;
            for (int n = 0; n < 40 && !got; n++) begin
                @(posedge clk_i);
                if (xcpt_commit_o.valid) act_x = xcpt_commit_o;
                if (commit_stall_o) stall_seen = 1'b1;
                else if (stall_seen) got = 1'b1;
            end
            @(negedge clk_i);
            commit_store_i = 1'b0;
            if (!got) begin
                errors++;
                $display("timeout in %s waiting for the store to finish", names[i]);
            end
            check_flag({names[i], " commit stall"}, 1'b1, stall_seen);
            check_index({names[i], " store gl_index"}, gl_index_t'(i + 1 + 10), store_gl_index_o);
            exp_x        = '0;
            exp_x.valid  = r.exp_xcpt;
            exp_x.cause  = r.exp_xcpt ? r.exp_cause : xcpt_cause_e'(4'd0);
            exp_x.origin = r.exp_xcpt ? r.addr : '0;
            if (!r.exp_xcpt) begin
                check_word({names[i], " memory"}, r.data, mem[r.addr[6:3]]);
                golden[r.addr[6:3]] = r.data;
            end
            check_xcpt({names[i], " exception"}, exp_x, act_x);
        end else begin
            got = 1'b0;
            for (int n = 0; n < 50 && !got; n++) begin
                @(posedge clk_i);
                if (wb_o.valid) begin
                    got    = 1'b1;
                    act_wb = wb_o;
                end
            end
            if (!got) begin
                errors++;
                $display("timeout in %s waiting for writeback", names[i]);
            end
            repeat (6) @(posedge clk_i);    // Catch a second writeback
            exp_wb = expect_load(r.addr, i + 1);
            if (r.exp_xcpt) begin
                exp_wb.result    = '0;
                exp_wb.ex.valid  = 1'b1;
                exp_wb.ex.cause  = r.exp_cause;
                exp_wb.ex.origin = r.addr;
            end
            check_wb(names[i], exp_wb, act_wb);
            check_flag({names[i], " single writeback"}, 1'b1, (wb_total - wb0) == 1);
            if (r.nack) begin
                check_flag({names[i], " kill pulse"}, 1'b1, kill_total > kill0);
                check_flag({names[i], " two requests"}, 1'b1, (req_total - req0) == 2);
                check_word({names[i], " first addr"}, r.addr, prev_addr);
                check_word({names[i], " replay addr"}, r.addr, last_addr);
            end
        end
        ma_en = 1'b0;
        pf_en = 1'b0;
        report_test(names[i], errs0);
    endtask

    initial begin
        logic [31:0] s;
        int          errs0;
        int          wb0;
        int          kill0;
        int          got;
        wb_t         act_wb;
        rstn_i         = 1'b0;
        flush_i        = 1'b0;
        commit_store_i = 1'b0;
        instr_i        = '0;
        dcache_resp_i  = '0;
        s = 32'h43c9;
        for (int k = 0; k < 16; k++) begin
            s             = xorshift(s);
            mem[k][63:32] = s;
            s             = xorshift(s);
            mem[k][31:0]  = s;
            golden[k]     = mem[k];
        end
        //      st    nack  ma    pf    addr                    data
        rows[0] = {1'b0, 1'b0, 1'b0, 1'b0, 64'h28, 64'h0, 1'b0, LD_MISALIGNED};
        rows[1] = {1'b1, 1'b0, 1'b0, 1'b0, 64'h28, 64'hdead_beef_0123_4567, 1'b0, LD_MISALIGNED};
        rows[2] = {1'b0, 1'b0, 1'b0, 1'b0, 64'h28, 64'h0, 1'b0, LD_MISALIGNED};
        rows[3] = {1'b0, 1'b1, 1'b0, 1'b0, 64'h40, 64'h0, 1'b0, LD_MISALIGNED};
        rows[4] = {1'b0, 1'b0, 1'b0, 1'b1, 64'h48, 64'h0, 1'b1, LD_PAGE_FAULT};
        rows[5] = {1'b1, 1'b0, 1'b1, 1'b0, 64'h53, 64'h55aa, 1'b1, ST_MISALIGNED};
        rows[6] = {1'b0, 1'b0, 1'b0, 1'b0, 64'h0000_8000_0000_0018, 64'h0, 1'b1, LD_ACCESS_FAULT};
        names   = '{"load_basic", "store_commit", "load_after_store", "load_nack_replay",
                    "load_page_fault", "store_misaligned", "load_noncanonical"};

        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;
        @(posedge clk_i);
        check_flag("reset empty", 1'b1, empty_o);
        check_flag("reset stall", 1'b0, commit_stall_o);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        // Back-pressure fills the queue
        errs0 = errors;
        @(negedge clk_i);
        ready_en = 1'b0;
        for (int k = 0; k < 4; k++) push_load(64'h60 + 64'(k * 8), 20 + k);
        @(negedge clk_i);
        instr_i = '0;
        got     = 0;
        for (int n = 0; n < 10 && got == 0; n++) begin
            @(posedge clk_i);
            if (lock_o) got = 1;
        end
        check_flag("lock_full lock", 1'b1, got == 1);
        @(negedge clk_i);
        ready_en = 1'b1;
        got = 0;
        for (int n = 0; n < 60 && got < 4; n++) begin
            @(posedge clk_i);
            if (wb_o.valid) begin
                act_wb = wb_o;
                check_wb("lock_full order", expect_load(64'h60 + 64'(got * 8), 20 + got), act_wb);
                got++;
            end
        end
        if (got < 4) begin
            errors++;
            $display("timeout in lock_full, only %0d loads finished", got);
        end
        report_test("lock_full", errs0);

        // Flush with loads waiting
        errs0 = errors;
        @(negedge clk_i);
        ready_en = 1'b0;
        push_load(64'h10, 30);
        push_load(64'h18, 31);
        @(negedge clk_i);
        instr_i = '0;
        wb0     = wb_total;
        kill0   = kill_total;
        @(negedge clk_i);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i  = 1'b0;
        ready_en = 1'b1;
        @(posedge clk_i);
        check_flag("flush empty", 1'b1, empty_o);
        check_flag("flush kill", 1'b1, kill_total > kill0);
        repeat (10) @(posedge clk_i);
        check_flag("flush no writeback", 1'b1, wb_total == wb0);
        report_test("flush", errs0);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/mem_unit_checker.sv
// Bound into mem_unit; properties are disabled while rstn_i is low
`default_nettype none

module mem_unit_checker (
    input logic                      clk_i,
    input logic                      rstn_i,
    input logic                      commit_store_i,
    input mem_unit_pkg::dcache_req_t req_i,
    input mem_unit_pkg::wb_t         wb_i,
    input mem_unit_pkg::exception_t  xcpt_i,
    input logic                      lock_i,
    input logic                      empty_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import mem_unit_pkg::*;

    ////////////////////
    // Properties
    ////////////////////

    a_store_needs_commit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (req_i.valid && req_i.is_store) |-> commit_store_i)
        else $error("store request while commit_store_i is low");

    a_one_result: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(wb_i.valid && xcpt_i.valid))
        else $error("writeback and commit exception in the same cycle");

    a_lock_not_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(lock_i && empty_i))
        else $error("lock_o and empty_o both high");

endmodule

bind mem_unit mem_unit_checker u_checker (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .commit_store_i (commit_store_i),
    .req_i          (dcache_req_o),
    .wb_i           (wb_o),
    .xcpt_i         (xcpt_commit_o),
    .lock_i         (lock_o),
    .empty_i        (empty_o)
);

`default_nettype wire

// File: rtl/mem_unit.sv
// The core must hold instr_i low while lock_o is high; flush_i empties the unit in one cycle
`default_nettype none

module mem_unit (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       flush_i,
    input  mem_unit_pkg::mem_instr_t   instr_i,
    input  logic                       commit_store_i,
    input  mem_unit_pkg::dcache_resp_t dcache_resp_i,
    output mem_unit_pkg::dcache_req_t  dcache_req_o,
    output mem_unit_pkg::wb_t          wb_o,
    output mem_unit_pkg::exception_t   xcpt_commit_o,
    output logic                       commit_stall_o,
    output mem_unit_pkg::gl_index_t    store_gl_index_o,
    output logic                       lock_o,
    output logic                       empty_o
);
    import mem_unit_pkg::*;

    mem_instr_t  lsq_next;
    logic        lsq_full;
    logic        lsq_empty;
    logic        read_next;
    logic        replay;
    logic        advance_head;
    logic        store_done;
    logic        load_done;
    dcache_req_t issue_req;
    mem_instr_t  issued;
    mem_instr_t  s2_instr;
    xlen_t       s2_addr;
    xlen_t       s1_store_data;
    logic        s2_xcpt_ma;
    logic        s2_xcpt_pf;
    tag_t        s2_tag;

    load_store_queue u_lsq (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instr_i        (instr_i),
        .flush_i        (flush_i),
        .read_next_i    (read_next),
        .rewind_i       (replay),
        .advance_head_i (advance_head),
        .next_instr_o   (lsq_next),
        .full_o         (lsq_full),
        .empty_o        (lsq_empty)
    );

    mem_issue_ctrl u_issue (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .flush_i          (flush_i),
        .next_instr_i     (lsq_next),
        .lsq_empty_i      (lsq_empty),
        .dcache_ready_i   (dcache_resp_i.ready),
        .dcache_nack_i    (dcache_resp_i.nack),
        .commit_store_i   (commit_store_i),
        .replay_i         (replay),
        .store_done_i     (store_done),
        .replay_tag_i     (s2_tag),
        .req_o            (issue_req),
        .issued_o         (issued),
        .read_next_o      (read_next),
        .commit_stall_o   (commit_stall_o),
        .store_gl_index_o (store_gl_index_o)
    );

    mem_resp_pipe u_resp (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .flush_i         (flush_i),
        .issued_i        (issued),
        .tag_i           (issue_req.tag),
        .addr_i          (issue_req.addr),
        .dcache_resp_i   (dcache_resp_i),
        .s2_instr_o      (s2_instr),
        .s2_addr_o       (s2_addr),
        .s2_xcpt_ma_o    (s2_xcpt_ma),
        .s2_xcpt_pf_o    (s2_xcpt_pf),
        .s2_tag_o        (s2_tag),
        .replay_o        (replay),
        .advance_head_o  (advance_head),
        .store_done_o    (store_done),
        .load_done_o     (load_done),
        .s1_store_data_o (s1_store_data)
    );

    mem_writeback u_wb (
        .s2_instr_i    (s2_instr),
        .s2_addr_i     (s2_addr),
        .xcpt_ma_i     (s2_xcpt_ma),
        .xcpt_pf_i     (s2_xcpt_pf),
        .load_done_i   (load_done),
        .resp_data_i   (dcache_resp_i.data),
        .wb_o          (wb_o),
        .xcpt_commit_o (xcpt_commit_o)
    );

    always_comb begin
        dcache_req_o            = issue_req;
        dcache_req_o.store_data = s1_store_data;   // Data of the request issued a cycle ago
    end

    assign lock_o  = lsq_full;
    assign empty_o = lsq_empty & ~issue_req.valid;

endmodule

`default_nettype wire

// File: rtl/mem_writeback.sv
// Combinational; cause priority is misaligned, page fault, then non-canonical address
`default_nettype none

module mem_writeback (
    input  mem_unit_pkg::mem_instr_t s2_instr_i,
    input  mem_unit_pkg::xlen_t      s2_addr_i,
    input  logic                     xcpt_ma_i,
    input  logic                     xcpt_pf_i,
    input  logic                     load_done_i,
    input  mem_unit_pkg::xlen_t      resp_data_i,
    output mem_unit_pkg::wb_t        wb_o,
    output mem_unit_pkg::exception_t xcpt_commit_o
);
    import mem_unit_pkg::*;

    exception_t ex;
    logic       access_fault;

    assign access_fault = is_noncanonical(s2_addr_i);

    ////////////////////
    // Classification
    ////////////////////

    always_comb begin
        ex.valid  = s2_instr_i.valid & (xcpt_ma_i | xcpt_pf_i | access_fault);
        ex.origin = s2_addr_i;
        if (xcpt_ma_i) begin
            ex.cause = s2_instr_i.is_store ? ST_MISALIGNED : LD_MISALIGNED;
        end else if (xcpt_pf_i) begin
            ex.cause = s2_instr_i.is_store ? ST_PAGE_FAULT : LD_PAGE_FAULT;
        end else begin
            ex.cause = s2_instr_i.is_store ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
        end
    end

    // Loads and their faults go to writeback
    always_comb begin
        wb_o.valid    = load_done_i;
        wb_o.rd       = s2_instr_i.rd;
        wb_o.gl_index = s2_instr_i.gl_index;
        wb_o.result   = ex.valid ? '0 : resp_data_i;
        wb_o.ex       = ex;
        wb_o.ex.valid = ex.valid & ~s2_instr_i.is_store;
    end

    // Store faults are raised at commit
    always_comb begin
        xcpt_commit_o       = ex;
        xcpt_commit_o.valid = ex.valid & s2_instr_i.is_store;
    end

endmodule

`default_nettype wire

// File: rtl/mem_resp_pipe.sv
// Response fields are sampled two cycles after the request; a nack in stage 2 forces a replay
`default_nettype none

module mem_resp_pipe (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       flush_i,
    input  mem_unit_pkg::mem_instr_t   issued_i,
    input  mem_unit_pkg::tag_t         tag_i,
    input  mem_unit_pkg::xlen_t        addr_i,
    input  mem_unit_pkg::dcache_resp_t dcache_resp_i,
    output mem_unit_pkg::mem_instr_t   s2_instr_o,
    output mem_unit_pkg::xlen_t        s2_addr_o,
    output logic                       s2_xcpt_ma_o,
    output logic                       s2_xcpt_pf_o,
    output mem_unit_pkg::tag_t         s2_tag_o,
    output logic                       replay_o,
    output logic                       advance_head_o,
    output logic                       store_done_o,
    output logic                       load_done_o,
    output mem_unit_pkg::xlen_t        s1_store_data_o
);
    import mem_unit_pkg::*;

    logic       s1_vld_q;
    logic       s2_vld_q;
    mem_instr_t s1_q;
    mem_instr_t s2_q;
    tag_t       s1_tag_q;
    tag_t       s2_tag_q;
    xlen_t      s1_addr_q;
    xlen_t      s2_addr_q;
    logic       xcpt;
    logic       complete;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_vld_q <= 1'b0;
            s2_vld_q <= 1'b0;
        end else if (flush_i || replay_o) begin
            s1_vld_q <= 1'b0;
            s2_vld_q <= 1'b0;
        end else begin
            s1_vld_q <= issued_i.valid;
            s2_vld_q <= s1_vld_q;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_q      <= issued_i;
        s1_tag_q  <= tag_i;
        s1_addr_q <= addr_i;
        s2_q      <= s1_q;
        s2_tag_q  <= s1_tag_q;
        s2_addr_q <= s1_addr_q;
    end

    assign s1_store_data_o = s1_q.store_data;  // Cache takes store data a cycle late

    ////////////////////
    // Stage 2 outcome
    ////////////////////

    assign s2_xcpt_ma_o = s2_vld_q & dcache_resp_i.xcpt_ma;
    assign s2_xcpt_pf_o = s2_vld_q & dcache_resp_i.xcpt_pf;
    assign xcpt         = s2_xcpt_ma_o | s2_xcpt_pf_o | (s2_vld_q & is_noncanonical(s2_addr_q));

    // Nack wins over everything, then exception or data
    assign replay_o = s2_vld_q & dcache_resp_i.nack & ~flush_i;
    assign complete = s2_vld_q & ~dcache_resp_i.nack & ~flush_i &
                      (xcpt | dcache_resp_i.valid);

    assign advance_head_o = complete;
    assign store_done_o   = complete & s2_q.is_store;
    assign load_done_o    = complete & ~s2_q.is_store;

    always_comb begin
        s2_instr_o       = s2_q;
        s2_instr_o.valid = complete;
    end

    assign s2_addr_o = s2_addr_q;
    assign s2_tag_o  = s2_tag_q;

endmodule

`default_nettype wire

// File: rtl/mem_issue_ctrl.sv
// One store in flight at a time; a store issues only while commit_store_i is high
`default_nettype none

module mem_issue_ctrl (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      flush_i,
    input  mem_unit_pkg::mem_instr_t  next_instr_i,
    input  logic                      lsq_empty_i,
    input  logic                      dcache_ready_i,
    input  logic                      dcache_nack_i,
    input  logic                      commit_store_i,
    input  logic                      replay_i,
    input  logic                      store_done_i,
    input  mem_unit_pkg::tag_t        replay_tag_i,
    output mem_unit_pkg::dcache_req_t req_o,
    output mem_unit_pkg::mem_instr_t  issued_o,
    output logic                      read_next_o,
    output logic                      commit_stall_o,
    output mem_unit_pkg::gl_index_t   store_gl_index_o
);
    import mem_unit_pkg::*;

    issue_state_e state_q;
    issue_state_e state_d;
    mem_instr_t   held_q;
    mem_instr_t   cur;
    logic         active;
    logic         store_ok;
    logic         fire;
    logic         stall_s0;
    logic         store_in_flight_q;
    tag_t         tag_q;

    // Queue head in READ_HEAD, held copy while waiting
    always_comb begin
        if (state_q == READ_HEAD) begin
            cur    = next_instr_i;
            active = ~lsq_empty_i;
        end else begin
            cur    = held_q;
            active = (state_q != RESET_ST);
        end
    end

    assign store_ok    = ~cur.is_store | (commit_store_i & ~store_in_flight_q);
    assign fire        = active & store_ok & dcache_ready_i & ~dcache_nack_i &
                         ~flush_i & ~replay_i;
    assign read_next_o = (state_q == READ_HEAD) & ~lsq_empty_i & ~flush_i & ~replay_i;

    ////////////////////
    // FSM
    ////////////////////

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            RESET_ST: begin
                state_d = READ_HEAD;
            end
            READ_HEAD, WAIT_READY: begin
                if (fire || !active) begin
                    state_d = READ_HEAD;
                end else if (cur.is_store && dcache_ready_i) begin
                    state_d = WAIT_COMMIT;  // Cache is free, commit is not
                end else begin
                    state_d = WAIT_READY;
                end
            end
            WAIT_COMMIT: begin
                if (fire) begin
                    state_d = READ_HEAD;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= RESET_ST;
        end else if (flush_i || replay_i) begin
            state_q <= READ_HEAD;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_next_o) begin
            held_q <= next_instr_i;
        end
    end

    // Wrapping request tag, rolled back to the nacked request on replay
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            tag_q <= '0;
        end else if (replay_i) begin
            tag_q <= replay_tag_i;
        end else if (fire) begin
            tag_q <= tag_q + 1'b1;
        end
    end

    ////////////////////
    // Store tracking
    ////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            store_in_flight_q <= 1'b0;
            store_gl_index_o  <= '0;
        end else if (flush_i || replay_i) begin
            store_in_flight_q <= 1'b0;  // A dropped store issues again
        end else if (fire && cur.is_store) begin
            store_in_flight_q <= 1'b1;
            store_gl_index_o  <= cur.gl_index;
        end else if (store_done_i) begin
            store_in_flight_q <= 1'b0;
        end
    end

    assign stall_s0       = active & cur.is_store & commit_store_i & ~store_in_flight_q;
    assign commit_stall_o = stall_s0 | (store_in_flight_q & ~store_done_i);

    always_comb begin
        req_o          = '0;    // Store data joins from stage 1
        req_o.valid    = fire;
        req_o.kill     = flush_i | replay_i;
        req_o.is_store = cur.is_store;
        req_o.size     = cur.size;
        req_o.tag      = tag_q;
        req_o.addr     = cur.base + cur.imm;
    end

    always_comb begin
        issued_o       = cur;
        issued_o.valid = fire;
    end

endmodule

`default_nettype wire

// File: rtl/load_store_queue.sv
// In-order queue; an entry stays until its response completes and rewind replays from the head
`default_nettype none

module load_store_queue (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  mem_unit_pkg::mem_instr_t instr_i,
    input  logic                     flush_i,
    input  logic                     read_next_i,
    input  logic                     rewind_i,
    input  logic                     advance_head_i,
    output mem_unit_pkg::mem_instr_t next_instr_o,
    output logic                     full_o,
    output logic                     empty_o
);
    import mem_unit_pkg::*;

    mem_instr_t entries_q [LSQ_DEPTH];
    lsq_ptr_t   head_q;     // Oldest unfinished entry
    lsq_ptr_t   exec_q;     // Next entry to issue
    lsq_ptr_t   tail_q;
    logic       push;

    assign full_o  = (tail_q[LSQ_IDX_BITS-1:0] == head_q[LSQ_IDX_BITS-1:0]) &&
                     (tail_q[LSQ_IDX_BITS] != head_q[LSQ_IDX_BITS]);
    assign empty_o = (exec_q == tail_q);    // Nothing left to issue
    assign push    = instr_i.valid & ~full_o & ~flush_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            entries_q[tail_q[LSQ_IDX_BITS-1:0]] <= instr_i;
        end
    end

    ////////////////////
    // Pointers
    ////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q <= '0;
            exec_q <= '0;
            tail_q <= '0;
        end else if (flush_i) begin
            head_q <= '0;
            exec_q <= '0;
            tail_q <= '0;
        end else begin
            if (push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (advance_head_i) begin
                head_q <= head_q + 1'b1;
            end
            if (rewind_i) begin
                exec_q <= head_q;   // Replay from the oldest unfinished entry
            end else if (read_next_i && !empty_o) begin
                exec_q <= exec_q + 1'b1;
            end
        end
    end

    always_comb begin
        next_instr_o       = entries_q[exec_q[LSQ_IDX_BITS-1:0]];
        next_instr_o.valid = ~empty_o;
    end

endmodule

`default_nettype wire

// File: rtl/mem_unit_pkg.sv
// Scalar RV64 loads and stores only, Sv39 addresses, a 4-entry queue and 5-bit cache tags
`default_nettype none

package mem_unit_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int XLEN          = 64;
    localparam int VADDR_BITS    = 39;
    localparam int LSQ_DEPTH     = 4;
    localparam int LSQ_IDX_BITS  = $clog2(LSQ_DEPTH);
    localparam int GL_INDEX_BITS = 6;
    localparam int TAG_BITS      = 5;
    localparam int REG_ADDR_BITS = 5;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [GL_INDEX_BITS-1:0] gl_index_t;
    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [LSQ_IDX_BITS:0]    lsq_ptr_t;    // MSB is the wrap bit

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W,
        SIZE_D
    } mem_size_e;

    typedef enum logic [1:0] {
        RESET_ST,
        READ_HEAD,
        WAIT_READY,
        WAIT_COMMIT
    } issue_state_e;

    // RISC-V mcause encodings
    typedef enum logic [3:0] {
        LD_MISALIGNED   = 4'd4,
        LD_ACCESS_FAULT = 4'd5,
        ST_MISALIGNED   = 4'd6,
        ST_ACCESS_FAULT = 4'd7,
        LD_PAGE_FAULT   = 4'd13,
        ST_PAGE_FAULT   = 4'd15
    } xcpt_cause_e;

    ////////////////////
    // Bundles
    ////////////////////

    typedef struct packed {
        logic      valid;
        logic      is_store;
        mem_size_e size;
        reg_addr_t rd;
        gl_index_t gl_index;
        xlen_t     base;
        xlen_t     imm;
        xlen_t     store_data;
    } mem_instr_t;

    typedef struct packed {
        logic      valid;
        logic      kill;        // Drops whatever the cache has in flight
        logic      is_store;
        mem_size_e size;
        tag_t      tag;
        xlen_t     addr;
        xlen_t     store_data;  // One cycle behind the request
    } dcache_req_t;

    typedef struct packed {
        logic  ready;
        logic  valid;
        logic  nack;
        logic  xcpt_ma;
        logic  xcpt_pf;
        xlen_t data;
    } dcache_resp_t;

    typedef struct packed {
        logic        valid;
        xcpt_cause_e cause;
        xlen_t       origin;
    } exception_t;

    typedef struct packed {
        logic       valid;
        reg_addr_t  rd;
        gl_index_t  gl_index;
        xlen_t      result;
        exception_t ex;
    } wb_t;

    // Sv39 canonical form needs bits 63 to 38 all equal
    function automatic logic is_noncanonical(xlen_t addr);
        return !((&addr[XLEN-1:VADDR_BITS-1]) || !(|addr[XLEN-1:VADDR_BITS-1]));
    endfunction

endpackage

`default_nettype wire
